/* src/decode_pkg.sv */
package decode_pkg;

    // machine widths
    localparam int DATA_WIDTH     = 32;
    localparam int GPR_NUM        = 32;
    localparam int REG_ADDR_WIDTH = $clog2(GPR_NUM);

    // alu operation codes
    typedef enum logic [7:0] {
        ALU_OP_NOP    = 8'h00,
        ALU_OP_ADD    = 8'h01,
        ALU_OP_SUB    = 8'h02,
        ALU_OP_AND    = 8'h03,
        ALU_OP_OR     = 8'h04,
        ALU_OP_XOR    = 8'h05,
        ALU_OP_LUI    = 8'h06,
        ALU_OP_PCADDU = 8'h07,
        ALU_OP_LL     = 8'h08,
        ALU_OP_SC     = 8'h09,
        ALU_OP_LD     = 8'h0a,
        ALU_OP_ST     = 8'h0b
    } alu_op_t;

    // result class, picks the execute unit output
    typedef enum logic [2:0] {
        ALU_SEL_NOP   = 3'd0,
        ALU_SEL_ARITH = 3'd1,
        ALU_SEL_LOGIC = 3'd2,
        ALU_SEL_MOVE  = 3'd3,
        ALU_SEL_MEM   = 3'd4
    } alu_sel_t;

    // 2ri14, instr[31:24]
    localparam logic [7:0] LL_W_OPC = 8'b0010_0000;
    localparam logic [7:0] SC_W_OPC = 8'b0010_0001;

    // 2ri12, instr[31:22]
    localparam logic [9:0] ADDI_W_OPC = 10'b00_0000_1010;
    localparam logic [9:0] ANDI_OPC   = 10'b00_0000_1101;
    localparam logic [9:0] ORI_OPC    = 10'b00_0000_1110;
    localparam logic [9:0] LD_W_OPC   = 10'b00_1010_0010;
    localparam logic [9:0] ST_W_OPC   = 10'b00_1010_0110;

    // 3r, instr[31:15]
    localparam logic [16:0] ADD_W_OPC = 17'h00020;
    localparam logic [16:0] SUB_W_OPC = 17'h00022;
    localparam logic [16:0] AND_OPC   = 17'h00029;
    localparam logic [16:0] OR_OPC    = 17'h0002a;
    localparam logic [16:0] XOR_OPC   = 17'h0002b;

    // 1ri20, instr[31:25]
    localparam logic [6:0] LU12I_W_OPC   = 7'b000_1010;
    localparam logic [6:0] PCADDU12I_OPC = 7'b000_1110;

    // word handed over by the instruction buffer
    typedef struct packed {
        logic [DATA_WIDTH-1:0] pc;
        logic [DATA_WIDTH-1:0] instr;
    } instr_buffer_info_t;

    // read slots are {rk, rj}
    typedef struct packed {
        logic                        valid;
        logic [1:0]                  reg_read_valid;
        logic [2*REG_ADDR_WIDTH-1:0] reg_read_addr;
        logic                        use_imm;
        logic [DATA_WIDTH-1:0]       imm;
        logic                        reg_write_valid;
        logic [REG_ADDR_WIDTH-1:0]   reg_write_addr;
        alu_op_t                     aluop;
        alu_sel_t                    alusel;
    } decode_result_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] pc;
        decode_result_t        result;
        logic                  illegal;
    } decoded_instr_t;

endpackage

/* src/decoder_2ri14.sv */
`timescale 1ns/1ps

// 2ri14 layout {opcode[8], imm14, rj, rd}
module decoder_2ri14 (
    input  decode_pkg::instr_buffer_info_t instr_info_i,
    output decode_pkg::decode_result_t     result_o
);

    logic [decode_pkg::DATA_WIDTH-1:0]     instr;
    logic [7:0]                            opc;
    logic [decode_pkg::REG_ADDR_WIDTH-1:0] rd;
    logic [decode_pkg::REG_ADDR_WIDTH-1:0] rj;
    logic [13:0]                           imm_14;

    assign instr  = instr_info_i.instr;
    assign opc    = instr[31:24];
    assign rd     = instr[4:0];
    assign rj     = instr[9:5];
    assign imm_14 = instr[23:10];

    always_comb begin
        result_o = '0;
        case (opc)
            decode_pkg::LL_W_OPC: begin
                result_o.valid           = 1'b1;
                result_o.use_imm         = 1'b1;
                result_o.imm             = {{18{imm_14[13]}}, imm_14};
                // only the rj slot
                result_o.reg_read_valid  = 2'b01;
                result_o.reg_read_addr   = {{decode_pkg::REG_ADDR_WIDTH{1'b0}}, rj};
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr  = rd;
                result_o.aluop           = decode_pkg::ALU_OP_LL;
                result_o.alusel          = decode_pkg::ALU_SEL_MOVE;
            end
            decode_pkg::SC_W_OPC: begin
                result_o.valid           = 1'b1;
                // offset still travels along for the address
                result_o.use_imm         = 1'b0;
                result_o.imm             = {{18{imm_14[13]}}, imm_14};
                // store data comes from rd in the rk slot
                result_o.reg_read_valid  = 2'b11;
                result_o.reg_read_addr   = {rd, rj};
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr  = rd;
                result_o.aluop           = decode_pkg::ALU_OP_SC;
                result_o.alusel          = decode_pkg::ALU_SEL_MOVE;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* src/decoder_2ri12.sv */
`timescale 1ns/1ps

// 2ri12 layout {opcode[10], imm12, rj, rd}
module decoder_2ri12 (
    input  decode_pkg::instr_buffer_info_t instr_info_i,
    output decode_pkg::decode_result_t     result_o
);

    logic [decode_pkg::DATA_WIDTH-1:0]     instr;
    logic [9:0]                            opc;
    logic [decode_pkg::REG_ADDR_WIDTH-1:0] rd;
    logic [decode_pkg::REG_ADDR_WIDTH-1:0] rj;
    logic [11:0]                           imm_12;
    logic [decode_pkg::DATA_WIDTH-1:0]     imm_sext;
    logic [decode_pkg::DATA_WIDTH-1:0]     imm_zext;

    assign instr  = instr_info_i.instr;
    assign opc    = instr[31:22];
    assign rd     = instr[4:0];
    assign rj     = instr[9:5];
    assign imm_12 = instr[21:10];

    assign imm_sext = {{20{imm_12[11]}}, imm_12};
    assign imm_zext = {20'b0, imm_12};

    always_comb begin
        // common shape, rj in and rd out with a signed immediate
        result_o                 = '0;
        result_o.valid           = 1'b1;
        result_o.use_imm         = 1'b1;
        result_o.imm             = imm_sext;
        result_o.reg_read_valid  = 2'b01;
        result_o.reg_read_addr   = {{decode_pkg::REG_ADDR_WIDTH{1'b0}}, rj};
        result_o.reg_write_valid = 1'b1;
        result_o.reg_write_addr  = rd;
        case (opc)
            decode_pkg::ADDI_W_OPC: begin
                result_o.aluop  = decode_pkg::ALU_OP_ADD;
                result_o.alusel = decode_pkg::ALU_SEL_ARITH;
            end
            decode_pkg::ANDI_OPC: begin
                // logic immediates are zero extended
                result_o.imm    = imm_zext;
                result_o.aluop  = decode_pkg::ALU_OP_AND;
                result_o.alusel = decode_pkg::ALU_SEL_LOGIC;
            end
            decode_pkg::ORI_OPC: begin
                result_o.imm    = imm_zext;
                result_o.aluop  = decode_pkg::ALU_OP_OR;
                result_o.alusel = decode_pkg::ALU_SEL_LOGIC;
            end
            decode_pkg::LD_W_OPC: begin
                result_o.aluop  = decode_pkg::ALU_OP_LD;
                result_o.alusel = decode_pkg::ALU_SEL_MEM;
            end
            decode_pkg::ST_W_OPC: begin
                // store reads rd as data and writes back nothing
                result_o.reg_read_valid  = 2'b11;
                result_o.reg_read_addr   = {rd, rj};
                result_o.reg_write_valid = 1'b0;
                result_o.reg_write_addr  = '0;
                result_o.aluop           = decode_pkg::ALU_OP_ST;
                result_o.alusel          = decode_pkg::ALU_SEL_MEM;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* src/decoder_3r.sv */
`timescale 1ns/1ps

// 3r layout {opcode[17], rk, rj, rd}
module decoder_3r (
    input  decode_pkg::instr_buffer_info_t instr_info_i,
    output decode_pkg::decode_result_t     result_o
);

    logic [decode_pkg::DATA_WIDTH-1:0]     instr;
    logic [16:0]                           opc;
    logic [decode_pkg::REG_ADDR_WIDTH-1:0] rd;
    logic [decode_pkg::REG_ADDR_WIDTH-1:0] rj;
    logic [decode_pkg::REG_ADDR_WIDTH-1:0] rk;

    assign instr = instr_info_i.instr;
    assign opc   = instr[31:15];
    assign rd    = instr[4:0];
    assign rj    = instr[9:5];
    assign rk    = instr[14:10];

    always_comb begin
        // every 3r word reads both sources and writes rd
        result_o                 = '0;
        result_o.valid           = 1'b1;
        result_o.reg_read_valid  = 2'b11;
        result_o.reg_read_addr   = {rk, rj};
        result_o.reg_write_valid = 1'b1;
        result_o.reg_write_addr  = rd;
        case (opc)
            decode_pkg::ADD_W_OPC: begin
                result_o.aluop  = decode_pkg::ALU_OP_ADD;
                result_o.alusel = decode_pkg::ALU_SEL_ARITH;
            end
            decode_pkg::SUB_W_OPC: begin
                result_o.aluop  = decode_pkg::ALU_OP_SUB;
                result_o.alusel = decode_pkg::ALU_SEL_ARITH;
            end
            decode_pkg::AND_OPC: begin
                result_o.aluop  = decode_pkg::ALU_OP_AND;
                result_o.alusel = decode_pkg::ALU_SEL_LOGIC;
            end
            decode_pkg::OR_OPC: begin
                result_o.aluop  = decode_pkg::ALU_OP_OR;
                result_o.alusel = decode_pkg::ALU_SEL_LOGIC;
            end
            decode_pkg::XOR_OPC: begin
                result_o.aluop  = decode_pkg::ALU_OP_XOR;
                result_o.alusel = decode_pkg::ALU_SEL_LOGIC;
            end
            default: begin
                // not a 3r word
                result_o = '0;
            end
        endcase
    end

endmodule

/* src/decoder_1ri20.sv */
`timescale 1ns/1ps

// 1ri20 layout {opcode[7], imm20, rd}
module decoder_1ri20 (
    input  decode_pkg::instr_buffer_info_t instr_info_i,
    output decode_pkg::decode_result_t     result_o
);

    logic [decode_pkg::DATA_WIDTH-1:0]     instr;
    logic [6:0]                            opc;
    logic [decode_pkg::REG_ADDR_WIDTH-1:0] rd;
    logic [19:0]                           imm_20;

    assign instr  = instr_info_i.instr;
    assign opc    = instr[31:25];
    assign rd     = instr[4:0];
    assign imm_20 = instr[24:5];

    always_comb begin
        // upper immediate, no register sources
        result_o                 = '0;
        result_o.valid           = 1'b1;
        result_o.use_imm         = 1'b1;
        result_o.imm             = {imm_20, 12'b0};
        result_o.reg_write_valid = 1'b1;
        result_o.reg_write_addr  = rd;
        case (opc)
            decode_pkg::LU12I_W_OPC: begin
                result_o.aluop  = decode_pkg::ALU_OP_LUI;
                result_o.alusel = decode_pkg::ALU_SEL_MOVE;
            end
            decode_pkg::PCADDU12I_OPC: begin
                // pc gets added in execute
                result_o.aluop  = decode_pkg::ALU_OP_PCADDU;
                result_o.alusel = decode_pkg::ALU_SEL_ARITH;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ps

// decode stage between instruction buffer and dispatch
module decode_stage (
    input  logic                           clk,
    input  logic                           rst_i,

    // from instruction buffer
    input  logic                           instr_valid_i,
    input  decode_pkg::instr_buffer_info_t instr_i,
    output logic                           instr_ready_o,

    // toward dispatch
    output logic                           dec_valid_o,
    output decode_pkg::decoded_instr_t     dec_o,
    input  logic                           dec_ready_i
);

    decode_pkg::decode_result_t res_2ri14;
    decode_pkg::decode_result_t res_2ri12;
    decode_pkg::decode_result_t res_3r;
    decode_pkg::decode_result_t res_1ri20;
    decode_pkg::decode_result_t res_sel;

    logic [3:0]                 claim;
    logic                       illegal;
    logic                       accept;
    decode_pkg::decoded_instr_t dec_d;
    decode_pkg::decoded_instr_t dec_q;
    logic                       dec_valid_q;

    // all format decoders look at the same word
    decoder_2ri14 decoder_2ri14_inst (
        .instr_info_i (instr_i),
        .result_o     (res_2ri14)
    );

    decoder_2ri12 decoder_2ri12_inst (
        .instr_info_i (instr_i),
        .result_o     (res_2ri12)
    );

    decoder_3r decoder_3r_inst (
        .instr_info_i (instr_i),
        .result_o     (res_3r)
    );

    decoder_1ri20 decoder_1ri20_inst (
        .instr_info_i (instr_i),
        .result_o     (res_1ri20)
    );

    // opcode sets are disjoint, so at most one bit is set
    assign claim = {res_1ri20.valid, res_3r.valid, res_2ri12.valid, res_2ri14.valid};

    always_comb begin
        case (claim)
            4'b0001: begin
                res_sel = res_2ri14;
            end
            4'b0010: begin
                res_sel = res_2ri12;
            end
            4'b0100: begin
                res_sel = res_3r;
            end
            4'b1000: begin
                res_sel = res_1ri20;
            end
            default: begin
                // nobody claimed the word
                res_sel = '0;
            end
        endcase
    end

    assign illegal = ~|claim;

    assign dec_d.pc      = instr_i.pc;
    assign dec_d.result  = res_sel;
    assign dec_d.illegal = illegal;

    // room when empty or when the held record leaves this cycle
    assign instr_ready_o = ~dec_valid_q | dec_ready_i;
    assign accept        = instr_valid_i & instr_ready_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dec_valid_q <= 1'b0;
        end else if (accept) begin
            dec_valid_q <= 1'b1;
        end else if (dec_ready_i) begin
            dec_valid_q <= 1'b0;
        end
    end

    // record only changes on a new acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            dec_q <= dec_d;
        end
    end

    assign dec_valid_o = dec_valid_q;
    assign dec_o       = dec_q;

endmodule

/* verification/decode_vectors.svh */
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// each entry holds instruction word, pc, expected decode result and expected illegal bit
typedef struct packed {
    logic [decode_pkg::DATA_WIDTH-1:0] instr;
    logic [decode_pkg::DATA_WIDTH-1:0] pc;
    decode_pkg::decode_result_t        result;
    logic                              illegal;
} vector_t;

localparam int NUM_VECTORS = 17;

vector_t vectors [NUM_VECTORS];
int      vector_fill;

task automatic add_vector(
    input logic [decode_pkg::DATA_WIDTH-1:0] instr,
    input logic [decode_pkg::DATA_WIDTH-1:0] pc,
    input logic                              illegal,
    input decode_pkg::decode_result_t        result
);
    vectors[vector_fill] = {instr, pc, result, illegal};
    vector_fill++;
endtask

// result fields in order valid, read slots {rk,rj}, read addrs, use_imm, imm, write, rd, op, class
task automatic load_vectors();
    vector_fill = 0;
    add_vector({decode_pkg::LL_W_OPC, 14'h0010, 5'd4, 5'd3}, 32'h1c00_0000, 1'b0,
               '{1'b1, 2'b01, {5'd0, 5'd4}, 1'b1, 32'h0000_0010, 1'b1, 5'd3,
                 decode_pkg::ALU_OP_LL, decode_pkg::ALU_SEL_MOVE});
    add_vector({decode_pkg::LL_W_OPC, 14'h3ffc, 5'd2, 5'd1}, 32'h1c00_0004, 1'b0,
               '{1'b1, 2'b01, {5'd0, 5'd2}, 1'b1, 32'hffff_fffc, 1'b1, 5'd1,
                 decode_pkg::ALU_OP_LL, decode_pkg::ALU_SEL_MOVE});
    // sc keeps the offset in imm but does not select it
    add_vector({decode_pkg::SC_W_OPC, 14'h2000, 5'd8, 5'd7}, 32'h1c00_0008, 1'b0,
               '{1'b1, 2'b11, {5'd7, 5'd8}, 1'b0, 32'hffff_e000, 1'b1, 5'd7,
                 decode_pkg::ALU_OP_SC, decode_pkg::ALU_SEL_MOVE});
    add_vector({decode_pkg::ADDI_W_OPC, 12'h800, 5'd6, 5'd5}, 32'h1c00_000c, 1'b0,
               '{1'b1, 2'b01, {5'd0, 5'd6}, 1'b1, 32'hffff_f800, 1'b1, 5'd5,
                 decode_pkg::ALU_OP_ADD, decode_pkg::ALU_SEL_ARITH});
    add_vector({decode_pkg::ANDI_OPC, 12'hf0f, 5'd10, 5'd9}, 32'h1c00_0010, 1'b0,
               '{1'b1, 2'b01, {5'd0, 5'd10}, 1'b1, 32'h0000_0f0f, 1'b1, 5'd9,
                 decode_pkg::ALU_OP_AND, decode_pkg::ALU_SEL_LOGIC});
    add_vector({decode_pkg::ORI_OPC, 12'h8a5, 5'd12, 5'd11}, 32'h1c00_0014, 1'b0,
               '{1'b1, 2'b01, {5'd0, 5'd12}, 1'b1, 32'h0000_08a5, 1'b1, 5'd11,
                 decode_pkg::ALU_OP_OR, decode_pkg::ALU_SEL_LOGIC});
    add_vector({decode_pkg::LD_W_OPC, 12'hffc, 5'd14, 5'd13}, 32'h1c00_0018, 1'b0,
               '{1'b1, 2'b01, {5'd0, 5'd14}, 1'b1, 32'hffff_fffc, 1'b1, 5'd13,
                 decode_pkg::ALU_OP_LD, decode_pkg::ALU_SEL_MEM});
    add_vector({decode_pkg::ST_W_OPC, 12'h804, 5'd16, 5'd15}, 32'h1c00_001c, 1'b0,
               '{1'b1, 2'b11, {5'd15, 5'd16}, 1'b1, 32'hffff_f804, 1'b0, 5'd0,
                 decode_pkg::ALU_OP_ST, decode_pkg::ALU_SEL_MEM});
    add_vector({decode_pkg::ADD_W_OPC, 5'd19, 5'd18, 5'd17}, 32'h1c00_0020, 1'b0,
               '{1'b1, 2'b11, {5'd19, 5'd18}, 1'b0, 32'h0000_0000, 1'b1, 5'd17,
                 decode_pkg::ALU_OP_ADD, decode_pkg::ALU_SEL_ARITH});
    add_vector({decode_pkg::SUB_W_OPC, 5'd22, 5'd21, 5'd20}, 32'h1c00_0024, 1'b0,
               '{1'b1, 2'b11, {5'd22, 5'd21}, 1'b0, 32'h0000_0000, 1'b1, 5'd20,
                 decode_pkg::ALU_OP_SUB, decode_pkg::ALU_SEL_ARITH});
    add_vector({decode_pkg::AND_OPC, 5'd25, 5'd24, 5'd23}, 32'h1c00_0040, 1'b0,
               '{1'b1, 2'b11, {5'd25, 5'd24}, 1'b0, 32'h0000_0000, 1'b1, 5'd23,
                 decode_pkg::ALU_OP_AND, decode_pkg::ALU_SEL_LOGIC});
    add_vector({decode_pkg::OR_OPC, 5'd28, 5'd27, 5'd26}, 32'h1c00_0044, 1'b0,
               '{1'b1, 2'b11, {5'd28, 5'd27}, 1'b0, 32'h0000_0000, 1'b1, 5'd26,
                 decode_pkg::ALU_OP_OR, decode_pkg::ALU_SEL_LOGIC});
    add_vector({decode_pkg::XOR_OPC, 5'd31, 5'd30, 5'd29}, 32'h1c00_0028, 1'b0,
               '{1'b1, 2'b11, {5'd31, 5'd30}, 1'b0, 32'h0000_0000, 1'b1, 5'd29,
                 decode_pkg::ALU_OP_XOR, decode_pkg::ALU_SEL_LOGIC});
    add_vector({decode_pkg::LU12I_W_OPC, 20'h12345, 5'd2}, 32'h1c00_002c, 1'b0,
               '{1'b1, 2'b00, 10'd0, 1'b1, 32'h1234_5000, 1'b1, 5'd2,
                 decode_pkg::ALU_OP_LUI, decode_pkg::ALU_SEL_MOVE});
    add_vector({decode_pkg::PCADDU12I_OPC, 20'hfffff, 5'd4}, 32'h1c00_0030, 1'b0,
               '{1'b1, 2'b00, 10'd0, 1'b1, 32'hffff_f000, 1'b1, 5'd4,
                 decode_pkg::ALU_OP_PCADDU, decode_pkg::ALU_SEL_ARITH});
    // two unclaimed words where the second looks like a 3r word with a foreign opcode
    add_vector(32'hffff_ffff, 32'h8000_0abc, 1'b1, '0);
    add_vector(32'h0010_8c41, 32'h1c00_0f00, 1'b1, '0);
endtask

`endif

/* verification/tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage;

    localparam int TIMEOUT_CYCLES = 50;

    logic                           clk;
    logic                           rst_i;
    logic                           instr_valid_i;
    decode_pkg::instr_buffer_info_t instr_i;
    logic                           instr_ready_o;
    logic                           dec_valid_o;
    decode_pkg::decoded_instr_t     dec_o;
    logic                           dec_ready_i;

    int     value_errors;
    int     protocol_errors;
    int     cycle;
    int     cur_index;
    int     received;
    int     expect_q[$];
    int     accept_cycle_q[$];
    logic   prev_valid;
    logic   prev_taken;
    logic   stall_en;
    logic   timed_out;
    integer seed;

    `include "decode_vectors.svh"

    decode_stage decode_stage_inst (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .dec_valid_o   (dec_valid_o),
        .dec_o         (dec_o),
        .dec_ready_i   (dec_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        value_errors++;
        $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic check_result(input decode_pkg::decode_result_t got,
                                input decode_pkg::decode_result_t exp, input string ctx);
        if (got.valid !== exp.valid)
            report_mismatch({ctx, " valid"}, got.valid, exp.valid);
        if (got.reg_read_valid !== exp.reg_read_valid)
            report_mismatch({ctx, " reg_read_valid"}, got.reg_read_valid, exp.reg_read_valid);
        if (got.reg_read_addr !== exp.reg_read_addr)
            report_mismatch({ctx, " reg_read_addr"}, got.reg_read_addr, exp.reg_read_addr);
        if (got.use_imm !== exp.use_imm)
            report_mismatch({ctx, " use_imm"}, got.use_imm, exp.use_imm);
        if (got.imm !== exp.imm)
            report_mismatch({ctx, " imm"}, got.imm, exp.imm);
        if (got.reg_write_valid !== exp.reg_write_valid)
            report_mismatch({ctx, " reg_write_valid"}, got.reg_write_valid, exp.reg_write_valid);
        if (got.reg_write_addr !== exp.reg_write_addr)
            report_mismatch({ctx, " reg_write_addr"}, got.reg_write_addr, exp.reg_write_addr);
        if (got.aluop !== exp.aluop)
            report_mismatch({ctx, " aluop"}, got.aluop, exp.aluop);
        if (got.alusel !== exp.alusel)
            report_mismatch({ctx, " alusel"}, got.alusel, exp.alusel);
    endtask

    task automatic check_illegal(input logic got, input logic exp, input string ctx);
        if (got !== exp)
            report_mismatch({ctx, " illegal"}, got, exp);
    endtask

    task automatic check_pc(input logic [decode_pkg::DATA_WIDTH-1:0] got,
                            input logic [decode_pkg::DATA_WIDTH-1:0] exp, input string ctx);
        if (got !== exp)
            report_mismatch({ctx, " pc"}, got, exp);
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_mismatch(what, got, exp);
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
            report_mismatch(what, got, exp);
    endtask

    // present one word and wait for the edge that takes it
    task automatic offer(input int idx, output int waited);
        cur_index     = idx;
        instr_valid_i = 1'b1;
        instr_i.pc    = vectors[idx].pc;
        instr_i.instr = vectors[idx].instr;
        waited        = 0;
        @(posedge clk);
        while (!instr_ready_o && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(posedge clk);
        end
        if (!instr_ready_o) begin
            protocol_errors++;
            timed_out = 1'b1;
            $display("word %0d was never accepted, instr_ready_o stayed low", idx);
        end
        #1;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((expect_q.size() != 0 || dec_valid_o) && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (expect_q.size() != 0 || dec_valid_o) begin
            protocol_errors++;
            timed_out = 1'b1;
            $display("%0d records never left the stage", expect_q.size());
        end
    endtask

    task automatic run_table(input logic back_to_back);
        int waited;
        for (int i = 0; i < NUM_VECTORS && !timed_out; i++) begin
            offer(i, waited);
            // with dispatch always ready no word may wait
            if (back_to_back)
                check_count(waited, 0, $sformatf("entry %0d stall cycles", i));
        end
        instr_valid_i = 1'b0;
        drain();
    endtask

    // random back-pressure from dispatch
    initial begin
        int rnd;
        seed        = 32'hc335;
        dec_ready_i = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            rnd = $random(seed);
            if (stall_en)
                dec_ready_i = rnd[0];
            else
                dec_ready_i = 1'b1;
        end
    end

    // watches both handshakes on every rising edge
    initial begin
        int    idx;
        string ctx;
        cycle      = 0;
        prev_valid = 1'b0;
        prev_taken = 1'b0;
        forever begin
            @(posedge clk);
            cycle++;
            if (!rst_i) begin
                // the register is full exactly while an accepted word is pending
                check_flag(instr_ready_o, expect_q.size() == 0 || dec_ready_i, "instr_ready_o");
                if (dec_valid_o && expect_q.size() == 0) begin
                    protocol_errors++;
                    $display("record with pc %h appeared with no word pending", dec_o.pc);
                end else if (dec_valid_o) begin
                    idx = expect_q[0];
                    ctx = $sformatf("entry %0d", idx);
                    // first edge this record is visible
                    if (!prev_valid || prev_taken)
                        check_count(cycle - accept_cycle_q[0], 1, {ctx, " latency"});
                    check_pc(dec_o.pc, vectors[idx].pc, ctx);
                    check_result(dec_o.result, vectors[idx].result, ctx);
                    check_illegal(dec_o.illegal, vectors[idx].illegal, ctx);
                    if (dec_ready_i) begin
                        void'(expect_q.pop_front());
                        void'(accept_cycle_q.pop_front());
                        received++;
                    end
                end
                prev_valid = dec_valid_o;
                prev_taken = dec_valid_o && dec_ready_i;
                if (instr_valid_i && instr_ready_o) begin
                    expect_q.push_back(cur_index);
                    accept_cycle_q.push_back(cycle);
                end
            end
        end
    end

    initial begin
        value_errors    = 0;
        protocol_errors = 0;
        received        = 0;
        cur_index       = 0;
        stall_en        = 1'b0;
        timed_out       = 1'b0;
        rst_i           = 1'b1;
        instr_valid_i   = 1'b0;
        instr_i         = '0;
        load_vectors();
        repeat (8) @(posedge clk);
        #1;
        rst_i = 1'b0;
        check_flag(dec_valid_o, 1'b0, "dec_valid_o after reset");
        check_flag(instr_ready_o, 1'b1, "instr_ready_o after reset");
        run_table(1'b1);
        if (!timed_out) begin
            @(posedge clk);
            stall_en = 1'b1;
            #1;
            run_table(1'b0);
        end
        check_count(received, 2 * NUM_VECTORS, "records delivered");
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+verification
src/decode_pkg.sv
src/decoder_2ri14.sv
src/decoder_2ri12.sv
src/decoder_3r.sv
src/decoder_1ri20.sv
src/decode_stage.sv
verification/tb_decode_stage.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - src/decode_pkg.sv
      - src/decoder_2ri14.sv
      - src/decoder_2ri12.sv
      - src/decoder_3r.sv
      - src/decoder_1ri20.sv
      - src/decode_stage.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_decode_stage.sv
